/* sim.f */
rtl/routing_pkg.sv
rtl/neighbor_table.sv
rtl/explore_rng.sv
rtl/winner_policy.sv
rtl/route_sequencer.sv
rtl/routing_node.sv
bench/routing_node_tb.sv

/* Bender.yml */
package:
  name: routing_node

sources:
  - rtl/routing_pkg.sv
  - rtl/neighbor_table.sv
  - rtl/explore_rng.sv
  - rtl/winner_policy.sv
  - rtl/route_sequencer.sv
  - rtl/routing_node.sv
  - target: simulation
    files:
      - bench/routing_node_tb.sv

/* bench/routing_node_tb.sv */
`timescale 1ns/10ps

module routing_node_tb;
	import routing_pkg::*;

	localparam int timeout_cycles = 200;

	logic clock, nrst, pkt_req, pkt_ack, res_req, res_ack, for_me, explored;
	logic [word_width-1:0] pkt_source_id, pkt_cluster_id, pkt_battery, pkt_q_value;
	logic [word_width-1:0] pkt_destination_id, next_hop, my_value;

	integer seed;
	int accepted, answered, wait_cycles;
	bit ack_seen, req_seen;

	// reference model state
	logic m_valid [table_size];
	logic [word_width-1:0] m_id [table_size], m_cluster [table_size];
	logic [word_width-1:0] m_battery [table_size], m_q [table_size];
	logic [word_width-1:0] m_lfsr, exp_hop, exp_value;
	logic [3:0] m_epsilon;
	logic exp_for_me, exp_explored;

	routing_node routing_node_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic int pick(input int range);
		return $unsigned($random(seed)) % range;
	endfunction

	function automatic logic usable(input int i);
		return m_valid[i] && m_cluster[i] == my_cluster_id && m_battery[i] >= battery_low;
	endfunction

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic wait_tick(input string what);
		@(negedge clock);
		wait_cycles++;
		assert (wait_cycles < timeout_cycles) else begin
			$display("timeout while waiting for %s", what);
			abort_run();
		end
	endtask

	// a pending request stays unanswered while the sink holds res_ack
	task automatic expect_no_accept();
		assert (pkt_ack === 1'b0) else begin
			$display("packet accepted while res_ack was still high");
			abort_run();
		end
	endtask

	// table insert, lfsr step, epsilon decay and pick rule
	task automatic predict();
		int slot;
		int best;
		int r;
		logic explore;
		logic [word_width-1:0] q;
		slot = -1;
		for (int i = table_size - 1; i >= 0; i--)
			if (!m_valid[i]) slot = i;
		for (int i = 0; i < table_size; i++)
			if (m_valid[i] && m_id[i] == pkt_source_id) slot = i;
		if (slot >= 0) begin
			m_valid[slot] = 1'b1;
			m_id[slot] = pkt_source_id;
			m_cluster[slot] = pkt_cluster_id;
			m_battery[slot] = pkt_battery;
			m_q[slot] = pkt_q_value;
		end
		m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? 16'hB400 : 16'h0000);
		explore = m_lfsr[3:0] < m_epsilon;
		r = m_lfsr[6:4];
		m_epsilon = (m_epsilon == 0) ? 4'd0 : m_epsilon - 4'd1;
		best = -1;
		for (int i = 0; i < table_size; i++)
			if (usable(i) && (best < 0 || m_q[i] < m_q[best])) best = i;
		exp_explored = explore && usable(r);
		if (exp_explored) begin
			exp_hop = m_id[r];
			q = m_q[r];
		end else if (best >= 0) begin
			exp_hop = m_id[best];
			q = m_q[best];
		end else begin
			exp_hop = '1;
			q = '1;
		end
		exp_value = (q == 16'hFFFF) ? 16'hFFFF : q + 16'd1;
		exp_for_me = (pkt_destination_id == my_node_id);
	endtask

	task automatic offer_packet();
		pkt_source_id = 16'h0040 + pick(12);
		pkt_cluster_id = pick(3);
		pkt_battery = 16'h0800 + pick(16'h1000);
		pkt_q_value = pick(2) ? pick(8) : $random(seed);
		pkt_destination_id = (pick(4) == 0) ? my_node_id : pick(8);
		predict();
		pkt_req = 1'b1;
	endtask

	task automatic complete_offer();
		wait_cycles = 0;
		while (pkt_ack !== 1'b1) wait_tick("pkt_ack to rise");
		pkt_req = 1'b0;
		wait_cycles = 0;
		while (pkt_ack !== 1'b0) wait_tick("pkt_ack to fall");
	endtask

	task automatic check_outputs();
		assert (res_req === 1'b1) else report_mismatch("res_req", res_req, 1'b1);
		assert (next_hop === exp_hop) else report_mismatch("next_hop", next_hop, exp_hop);
		assert (my_value === exp_value) else report_mismatch("my_value", my_value, exp_value);
		assert (for_me === exp_for_me) else report_mismatch("for_me", for_me, exp_for_me);
		assert (explored === exp_explored) else
			report_mismatch("explored", explored, exp_explored);
	endtask

	task automatic collect_result(input bit offer_next);
		int hold;
		int linger;
		wait_cycles = 0;
		while (res_req !== 1'b1) wait_tick("res_req to rise");
		// outputs hold while the sink stalls
		hold = pick(6);
		check_outputs();
		repeat (hold) begin
			@(negedge clock);
			check_outputs();
		end
		// next packet waits on the request line until this result is released
		if (offer_next)
			offer_packet();
		res_ack = 1'b1;
		wait_cycles = 0;
		while (res_req !== 1'b0) begin
			wait_tick("res_req to fall");
			expect_no_accept();
		end
		linger = pick(3);
		repeat (linger) begin
			@(negedge clock);
			expect_no_accept();
		end
		res_ack = 1'b0;
	endtask

	// each acceptance must follow a released result
	always @(negedge clock) begin
		if (pkt_ack === 1'b1 && !ack_seen) begin
			assert (accepted == answered) else begin
				$display("packet accepted before result %0d was released", answered);
				abort_run();
			end
			accepted++;
		end
		if (res_req === 1'b0 && req_seen)
			answered++;
		ack_seen = (pkt_ack === 1'b1);
		req_seen = (res_req === 1'b1);
	end

	initial begin
		seed = 67740;
		nrst = 1'b0;
		pkt_req = 1'b0;
		res_ack = 1'b0;
		pkt_source_id = '0;
		pkt_cluster_id = '0;
		pkt_battery = '0;
		pkt_q_value = '0;
		pkt_destination_id = '0;
		m_lfsr = lfsr_seed;
		m_epsilon = initial_epsilon;
		for (int i = 0; i < table_size; i++)
			m_valid[i] = 1'b0;
		repeat (16) @(negedge clock);
		nrst = 1'b1;
		// quiet until the first request
		repeat (5) begin
			@(negedge clock);
			assert (pkt_ack === 1'b0 && res_req === 1'b0) else begin
				$display("pkt_ack or res_req rose before any packet was offered");
				abort_run();
			end
		end
		offer_packet();
		for (int n = 0; n < 300; n++) begin
			complete_offer();
			collect_result(n < 299);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* rtl/routing_node.sv */
`timescale 1ns/10ps

module routing_node (
	input logic clock,
	input logic nrst,
	input logic pkt_req,
	output logic pkt_ack,
	input logic [routing_pkg::word_width-1:0] pkt_source_id,
	input logic [routing_pkg::word_width-1:0] pkt_cluster_id,
	input logic [routing_pkg::word_width-1:0] pkt_battery,
	input logic [routing_pkg::word_width-1:0] pkt_q_value,
	input logic [routing_pkg::word_width-1:0] pkt_destination_id,
	output logic res_req,
	input logic res_ack,
	output logic [routing_pkg::word_width-1:0] next_hop,
	output logic [routing_pkg::word_width-1:0] my_value,
	output logic for_me,
	output logic explored
);
	import routing_pkg::*;

	logic start, decide;
	logic table_done, rng_done, policy_valid;
	logic explore;
	logic [index_width-1:0] rand_index, peek_index;
	logic peek_valid, best_valid;
	logic [word_width-1:0] peek_id, peek_q, best_id, best_q;

	route_sequencer route_sequencer_i (
		.clock(clock), .nrst(nrst),
		.pkt_req(pkt_req), .pkt_ack(pkt_ack),
		.res_ack(res_ack), .res_req(res_req),
		.table_done(table_done), .rng_done(rng_done), .policy_valid(policy_valid),
		.start(start), .decide(decide)
	);

	neighbor_table neighbor_table_i (
		.clock(clock), .nrst(nrst), .start(start),
		.pkt_source_id(pkt_source_id), .pkt_cluster_id(pkt_cluster_id),
		.pkt_battery(pkt_battery), .pkt_q_value(pkt_q_value),
		.peek_index(peek_index), .peek_valid(peek_valid),
		.peek_id(peek_id), .peek_q(peek_q),
		.best_valid(best_valid), .best_id(best_id), .best_q(best_q),
		.table_done(table_done)
	);

	explore_rng explore_rng_i (
		.clock(clock), .nrst(nrst), .start(start),
		.explore(explore), .rand_index(rand_index), .rng_done(rng_done)
	);

	winner_policy winner_policy_i (
		.clock(clock), .nrst(nrst), .start(start), .decide(decide),
		.pkt_destination_id(pkt_destination_id),
		.explore(explore), .rand_index(rand_index),
		.peek_index(peek_index), .peek_valid(peek_valid),
		.peek_id(peek_id), .peek_q(peek_q),
		.best_valid(best_valid), .best_id(best_id), .best_q(best_q),
		.next_hop(next_hop), .my_value(my_value),
		.for_me(for_me), .explored(explored), .policy_valid(policy_valid)
	);

endmodule

/* rtl/route_sequencer.sv */
`timescale 1ns/10ps

module route_sequencer (
	input logic clock,
	input logic nrst,
	input logic pkt_req,
	output logic pkt_ack,
	input logic res_ack,
	output logic res_req,
	input logic table_done,
	input logic rng_done,
	input logic policy_valid,
	output logic start,
	output logic decide
);
	import routing_pkg::*;

	seq_state_t state;

	// accept only with both handshakes fully released
	assign start = (state == seq_idle) && pkt_req && !pkt_ack && !res_ack;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= seq_idle;
			pkt_ack <= 1'b0;
			res_req <= 1'b0;
			decide <= 1'b0;
		end else begin
			decide <= 1'b0;
			// input side
			if (start)
				pkt_ack <= 1'b1;
			else if (!pkt_req)
				pkt_ack <= 1'b0;
			case (state)
				seq_idle: begin
					if (start)
						state <= seq_compute;
				end
				seq_compute: begin
					if (table_done && rng_done) begin
						decide <= 1'b1;
						state <= seq_respond;
					end
				end
				seq_respond: begin
					if (!res_req && policy_valid) begin
						res_req <= 1'b1;
					end else if (res_req && res_ack) begin
						res_req <= 1'b0;
						state <= seq_release;
					end
				end
				seq_release: begin
					// wait for sink release and input ack drop
					if (!res_ack && !pkt_ack)
						state <= seq_idle;
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

/* rtl/winner_policy.sv */
`timescale 1ns/10ps

module winner_policy (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic decide,
	input logic [routing_pkg::word_width-1:0] pkt_destination_id,
	input logic explore,
	input logic [routing_pkg::index_width-1:0] rand_index,
	output logic [routing_pkg::index_width-1:0] peek_index,
	input logic peek_valid,
	input logic [routing_pkg::word_width-1:0] peek_id,
	input logic [routing_pkg::word_width-1:0] peek_q,
	input logic best_valid,
	input logic [routing_pkg::word_width-1:0] best_id,
	input logic [routing_pkg::word_width-1:0] best_q,
	output logic [routing_pkg::word_width-1:0] next_hop,
	output logic [routing_pkg::word_width-1:0] my_value,
	output logic for_me,
	output logic explored,
	output logic policy_valid
);
	import routing_pkg::*;

	logic [word_width-1:0] dest_id;
	logic [word_width-1:0] pick_id;
	logic [word_width-1:0] pick_q;
	logic pick_random;
	logic pick_any;
	logic [word_width:0] cost_sum;
	logic [word_width-1:0] pick_value;

	// random candidate comes straight from the rng index
	assign peek_index = rand_index;

	assign pick_random = explore && peek_valid;
	assign pick_any = pick_random || best_valid;
	assign pick_id = pick_random ? peek_id : best_id;
	assign pick_q = pick_random ? peek_q : best_q;

	// q plus hop cost, clamped at all ones
	assign cost_sum = {1'b0, pick_q} + {1'b0, hop_cost};
	assign pick_value = cost_sum[word_width] ? no_route : cost_sum[word_width-1:0];

	// destination is captured at acceptance, the source may move on afterwards
	always_ff @(posedge clock) begin
		if (start)
			dest_id <= pkt_destination_id;
		if (decide) begin
			next_hop <= pick_any ? pick_id : no_route;
			my_value <= pick_any ? pick_value : no_route;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			for_me <= 1'b0;
			explored <= 1'b0;
			policy_valid <= 1'b0;
		end else begin
			policy_valid <= decide;
			if (decide) begin
				for_me <= (dest_id == my_node_id);
				explored <= pick_random;
			end
		end
	end

endmodule

/* rtl/explore_rng.sv */
`timescale 1ns/10ps

module explore_rng (
	input logic clock,
	input logic nrst,
	input logic start,
	output logic explore,
	output logic [routing_pkg::index_width-1:0] rand_index,
	output logic rng_done
);
	import routing_pkg::*;

	logic [word_width-1:0] lfsr;
	logic [word_width-1:0] lfsr_next;
	logic [epsilon_width-1:0] epsilon;
	logic [epsilon_width-1:0] epsilon_next;

	// galois step, shifting right
	always_comb begin
		lfsr_next = lfsr >> 1;
		if (lfsr[0])
			lfsr_next = lfsr_next ^ lfsr_taps;
	end

	// decay saturates at zero
	assign epsilon_next = (epsilon > epsilon_step) ? epsilon - epsilon_step : '0;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			lfsr <= lfsr_seed;
			epsilon <= initial_epsilon;
			explore <= 1'b0;
			rand_index <= '0;
			rng_done <= 1'b0;
		end else if (start) begin
			lfsr <= lfsr_next;
			// decision uses epsilon before this packet's decay
			explore <= (lfsr_next[3:0] < epsilon);
			rand_index <= lfsr_next[6:4];
			epsilon <= epsilon_next;
			rng_done <= 1'b1;
		end
	end

endmodule

/* rtl/neighbor_table.sv */
`timescale 1ns/10ps

module neighbor_table (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic [routing_pkg::word_width-1:0] pkt_source_id,
	input logic [routing_pkg::word_width-1:0] pkt_cluster_id,
	input logic [routing_pkg::word_width-1:0] pkt_battery,
	input logic [routing_pkg::word_width-1:0] pkt_q_value,
	input logic [routing_pkg::index_width-1:0] peek_index,
	output logic peek_valid,
	output logic [routing_pkg::word_width-1:0] peek_id,
	output logic [routing_pkg::word_width-1:0] peek_q,
	output logic best_valid,
	output logic [routing_pkg::word_width-1:0] best_id,
	output logic [routing_pkg::word_width-1:0] best_q,
	output logic table_done
);
	import routing_pkg::*;

	table_phase_t phase;
	logic [table_size-1:0] entry_valid;
	logic [word_width-1:0] entry_id [table_size];
	logic [word_width-1:0] entry_cluster [table_size];
	logic [word_width-1:0] entry_battery [table_size];
	logic [word_width-1:0] entry_q [table_size];
	logic [word_width-1:0] new_id, new_cluster, new_battery, new_q;
	logic [index_width-1:0] scan_index;
	logic match_found, free_found;
	logic [index_width-1:0] match_index, free_index;
	logic write_en;
	logic [index_width-1:0] write_index;
	logic scan_hit;

	// same-cluster neighbor with enough battery left
	function automatic logic qualifies(input logic valid, input logic [word_width-1:0] cluster,
			input logic [word_width-1:0] battery);
		return valid && (cluster == my_cluster_id) && (battery >= battery_low);
	endfunction

	// descending walk so the lowest free slot wins
	always_comb begin
		match_found = 1'b0;
		match_index = '0;
		free_found = 1'b0;
		free_index = '0;
		for (int i = table_size - 1; i >= 0; i--) begin
			if (entry_valid[i] && entry_id[i] == new_id) begin
				match_found = 1'b1;
				match_index = index_width'(i);
			end
			if (!entry_valid[i]) begin
				free_found = 1'b1;
				free_index = index_width'(i);
			end
		end
	end

	// full table with an unknown source drops the update
	assign write_en = (phase == phase_update) && (match_found || free_found);
	assign write_index = match_found ? match_index : free_index;

	// strict compare keeps the lower index on ties
	assign scan_hit = (phase == phase_scan)
		&& qualifies(entry_valid[scan_index], entry_cluster[scan_index], entry_battery[scan_index])
		&& (!best_valid || entry_q[scan_index] < best_q);

	assign peek_valid = qualifies(entry_valid[peek_index], entry_cluster[peek_index],
		entry_battery[peek_index]);
	assign peek_id = entry_id[peek_index];
	assign peek_q = entry_q[peek_index];
	assign table_done = (phase == phase_done);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			phase <= phase_idle;
			entry_valid <= '0;
			best_valid <= 1'b0;
			scan_index <= '0;
		end else if (start) begin
			phase <= phase_update;
			best_valid <= 1'b0;
		end else begin
			case (phase)
				phase_update: begin
					if (write_en)
						entry_valid[write_index] <= 1'b1;
					scan_index <= '0;
					phase <= phase_scan;
				end
				phase_scan: begin
					if (scan_hit)
						best_valid <= 1'b1;
					if (scan_index == index_width'(table_size - 1))
						phase <= phase_done;
					else
						scan_index <= scan_index + 1'b1;
				end
				default: phase <= phase;
			endcase
		end
	end

	// packet fields and table contents
	always_ff @(posedge clock) begin
		if (start) begin
			new_id <= pkt_source_id;
			new_cluster <= pkt_cluster_id;
			new_battery <= pkt_battery;
			new_q <= pkt_q_value;
		end
		if (write_en) begin
			entry_id[write_index] <= new_id;
			entry_cluster[write_index] <= new_cluster;
			entry_battery[write_index] <= new_battery;
			entry_q[write_index] <= new_q;
		end
		if (scan_hit) begin
			best_id <= entry_id[scan_index];
			best_q <= entry_q[scan_index];
		end
	end

endmodule

/* rtl/routing_pkg.sv */
package routing_pkg;

	// datapath widths
	localparam int word_width = 16;
	localparam int table_size = 8;
	localparam int index_width = 3;
	localparam int epsilon_width = 4;

	// identity of this node
	localparam logic [word_width-1:0] my_node_id = 16'd3;
	localparam logic [word_width-1:0] my_cluster_id = 16'd1;

	// exploration schedule, epsilon on a 0..15 scale
	localparam logic [epsilon_width-1:0] initial_epsilon = 4'd7;
	localparam logic [epsilon_width-1:0] epsilon_step = 4'd1;
	localparam logic [word_width-1:0] lfsr_seed = 16'hACE1;

	// galois feedback mask for taps 16, 14, 13, 11
	localparam logic [word_width-1:0] lfsr_taps = 16'hB400;

	// cost rules
	localparam logic [word_width-1:0] hop_cost = 16'd1;
	localparam logic [word_width-1:0] battery_low = 16'h1000;
	localparam logic [word_width-1:0] no_route = '1;

	typedef enum logic [1:0] {
		seq_idle,
		seq_compute,
		seq_respond,
		seq_release
	} seq_state_t;

	typedef enum logic [1:0] {
		phase_idle,
		phase_update,
		phase_scan,
		phase_done
	} table_phase_t;

endpackage
